//--- verilog/vec_pkg.sv
`default_nettype none

package vec_pkg;

  //////////////////////////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned NR_LANES       = 4;
  localparam int unsigned ELEMS_PER_LANE = 4;
  // Element i of a register lives in lane i % 4, slot i / 4
  localparam int unsigned MAX_VL         = NR_LANES * ELEMS_PER_LANE;
  localparam int unsigned NR_VREGS       = 8;
  localparam int unsigned ELEM_W         = 32;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [ELEM_W-1:0]                 elem_t;
  typedef logic [$clog2(NR_VREGS)-1:0]       vreg_idx_t;
  typedef logic [$clog2(ELEMS_PER_LANE)-1:0] slot_t;
  // One extra bit so that a full vector length fits
  typedef logic [$clog2(MAX_VL+1)-1:0]       vl_t;
  typedef logic [NR_LANES-1:0]               lane_mask_t;

  // Instructions accepted from the scalar core
  typedef enum logic [3:0] {
    OP_SETVL   = 4'h0,
    OP_VADD_VV = 4'h1,
    OP_VSUB_VV = 4'h2,
    OP_VAND_VV = 4'h3,
    OP_VXOR_VV = 4'h4,
    OP_VADD_VX = 4'h5,
    // Broadcast scalar into vd
    OP_VMV_VX  = 4'h6,
    // Scalar results
    OP_VREDSUM = 4'h7,
    OP_VMV_XS  = 4'h8
  } vec_op_e;

endpackage

`default_nettype wire

//--- verilog/vec_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module vec_dispatcher import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Scalar core request
  input  vec_op_e   acc_op_i,
  input  vreg_idx_t acc_vd_i,
  input  vreg_idx_t acc_vs1_i,
  input  vreg_idx_t acc_vs2_i,
  input  elem_t     acc_scalar_i,
  input  logic      acc_req_valid_i,
  output logic      acc_req_ready_o,
  // Scalar core response
  output elem_t     acc_resp_data_o,
  output logic      acc_resp_valid_o,
  input  logic      acc_resp_ready_i,
  // Sequencer
  output vec_op_e   seq_op_o,
  output vreg_idx_t seq_vd_o,
  output vreg_idx_t seq_vs1_o,
  output vreg_idx_t seq_vs2_o,
  output elem_t     seq_scalar_o,
  output vl_t       seq_vl_o,
  output logic      seq_valid_o,
  input  logic      seq_ready_i,
  // Reduction unit
  input  elem_t     red_sum_i,
  input  logic      red_done_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_RESP
  } disp_state_e;

  disp_state_e state_q;
  disp_state_e state_d;
  vl_t         vl_q;
  vl_t         new_vl;
  elem_t       resp_q;
  logic        is_setvl;
  logic        needs_result;
  logic        req_fire;

  //////////////////////////////////////////////////////////////////////
  // Request decode
  //////////////////////////////////////////////////////////////////////

  assign is_setvl     = (acc_op_i == OP_SETVL);
  assign needs_result = (acc_op_i == OP_VREDSUM) || (acc_op_i == OP_VMV_XS);

  // SETVL runs here, so it does not wait for the sequencer
  assign acc_req_ready_o = (state_q == ST_IDLE) && (is_setvl || seq_ready_i);
  assign req_fire        = acc_req_valid_i && acc_req_ready_o;

  // Clamp requested length to the register size
  assign new_vl = (acc_scalar_i > MAX_VL) ? vl_t'(MAX_VL) : vl_t'(acc_scalar_i);

  assign seq_valid_o  = acc_req_valid_i && (state_q == ST_IDLE) && !is_setvl;
  assign seq_op_o     = acc_op_i;
  assign seq_vd_o     = acc_vd_i;
  assign seq_vs1_o    = acc_vs1_i;
  assign seq_vs2_o    = acc_vs2_i;
  assign seq_scalar_o = acc_scalar_i;
  assign seq_vl_o     = vl_q;

  //////////////////////////////////////////////////////////////////////
  // Response FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (req_fire && is_setvl) begin
          state_d = ST_RESP;
        end else if (req_fire && needs_result) begin
          state_d = ST_WAIT;
        end
      end
      ST_WAIT: begin
        if (red_done_i) begin
          state_d = ST_RESP;
        end
      end
      ST_RESP: begin
        if (acc_resp_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      vl_q    <= vl_t'(MAX_VL);
    end else begin
      state_q <= state_d;
      if (req_fire && is_setvl) begin
        vl_q <= new_vl;
      end
    end
  end

  // Response data held until the core takes it
  always_ff @(posedge clk_i) begin
    if (req_fire && is_setvl) begin
      resp_q <= elem_t'(new_vl);
    end else if ((state_q == ST_WAIT) && red_done_i) begin
      resp_q <= red_sum_i;
    end
  end

  assign acc_resp_valid_o = (state_q == ST_RESP);
  assign acc_resp_data_o  = resp_q;

endmodule

`default_nettype wire

//--- verilog/vec_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module vec_sequencer import vec_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  // Dispatcher
  input  vec_op_e    seq_op_i,
  input  vreg_idx_t  seq_vd_i,
  input  vreg_idx_t  seq_vs1_i,
  input  vreg_idx_t  seq_vs2_i,
  input  elem_t      seq_scalar_i,
  input  vl_t        seq_vl_i,
  input  logic       seq_valid_i,
  output logic       seq_ready_o,
  // Beat broadcast to the lanes
  output logic       beat_valid_o,
  output vec_op_e    beat_op_o,
  output slot_t      beat_slot_o,
  output vreg_idx_t  beat_vd_o,
  output vreg_idx_t  beat_vs1_o,
  output vreg_idx_t  beat_vs2_o,
  output elem_t      beat_scalar_o,
  output lane_mask_t beat_en_o,
  output logic       beat_last_o
);

  logic      busy_q;
  logic      first_q;
  vec_op_e   op_q;
  vl_t       vl_q;
  slot_t     slot_q;
  slot_t     last_slot_q;
  vreg_idx_t vd_q;
  vreg_idx_t vs1_q;
  vreg_idx_t vs2_q;
  elem_t     scalar_q;
  // Destinations of beats in the lane read and execute stages
  logic      p1_wr_q;
  logic      p2_wr_q;
  vreg_idx_t p1_vd_q;
  vreg_idx_t p2_vd_q;

  logic      accept;
  logic      fire;
  logic      stall;
  logic      no_beats;
  vl_t       vl_m1;
  slot_t     first_slot;
  slot_t     last_slot;

  function automatic logic writes_vd(vec_op_e op);
    return !((op == OP_VREDSUM) || (op == OP_VMV_XS));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Slot range of the incoming instruction
  //////////////////////////////////////////////////////////////////////

  assign vl_m1    = seq_vl_i - 5'd1;
  // Element ops with vl zero are retired at once
  assign no_beats = (seq_vl_i == '0) && writes_vd(seq_op_i);

  always_comb begin
    if (seq_op_i == OP_VMV_XS) begin
      // Element index taken modulo 16
      first_slot = seq_scalar_i[3:2];
      last_slot  = seq_scalar_i[3:2];
    end else begin
      first_slot = '0;
      last_slot  = (seq_vl_i == '0) ? slot_t'(0) : vl_m1[3:2];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Issue
  //////////////////////////////////////////////////////////////////////

  // Later beats of an instruction trail its first beat, so only that one is checked
  assign stall = first_q &&
                 ((p1_wr_q && ((p1_vd_q == vs1_q) || (p1_vd_q == vs2_q))) ||
                  (p2_wr_q && ((p2_vd_q == vs1_q) || (p2_vd_q == vs2_q))));

  assign fire        = busy_q && !stall;
  assign beat_last_o = (slot_q == last_slot_q);
  assign seq_ready_o = !busy_q || (fire && beat_last_o);
  assign accept      = seq_valid_i && seq_ready_o;

  always_comb begin
    for (int l = 0; l < NR_LANES; l++) begin
      if (op_q == OP_VMV_XS) begin
        beat_en_o[l] = (scalar_q[1:0] == l[1:0]);
      end else begin
        beat_en_o[l] = ({slot_q, l[1:0]} < vl_q);
      end
    end
  end

  assign beat_valid_o  = fire;
  assign beat_op_o     = op_q;
  assign beat_slot_o   = slot_q;
  assign beat_vd_o     = vd_q;
  assign beat_vs1_o    = vs1_q;
  assign beat_vs2_o    = vs2_q;
  assign beat_scalar_o = scalar_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q      <= 1'b0;
      first_q     <= 1'b0;
      op_q        <= OP_VADD_VV;
      vl_q        <= '0;
      slot_q      <= '0;
      last_slot_q <= '0;
      p1_wr_q     <= 1'b0;
      p2_wr_q     <= 1'b0;
      p1_vd_q     <= '0;
      p2_vd_q     <= '0;
    end else begin
      p1_wr_q <= fire && writes_vd(op_q);
      p1_vd_q <= vd_q;
      p2_wr_q <= p1_wr_q;
      p2_vd_q <= p1_vd_q;
      if (accept) begin
        busy_q      <= !no_beats;
        first_q     <= 1'b1;
        op_q        <= seq_op_i;
        vl_q        <= seq_vl_i;
        slot_q      <= first_slot;
        last_slot_q <= last_slot;
      end else if (fire) begin
        first_q <= 1'b0;
        if (beat_last_o) begin
          busy_q <= 1'b0;
        end else begin
          slot_q <= slot_q + 2'd1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      vd_q     <= seq_vd_i;
      vs1_q    <= seq_vs1_i;
      vs2_q    <= seq_vs2_i;
      scalar_q <= seq_scalar_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/vec_lane.sv
`timescale 1ns/1ps
`default_nettype none

module vec_lane import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Beat from the sequencer
  input  logic      beat_valid_i,
  input  vec_op_e   beat_op_i,
  input  slot_t     beat_slot_i,
  input  vreg_idx_t beat_vd_i,
  input  vreg_idx_t beat_vs1_i,
  input  vreg_idx_t beat_vs2_i,
  input  elem_t     beat_scalar_i,
  input  logic      beat_en_i,
  input  logic      beat_last_i,
  // Reduction unit
  output elem_t     red_elem_o,
  output logic      red_valid_o,
  output logic      red_last_o
);

  // Register file slice of this lane
  elem_t     rf_q [NR_VREGS][ELEMS_PER_LANE];

  // Read stage
  logic      s1_valid_q;
  logic      s1_en_q;
  logic      s1_last_q;
  vec_op_e   s1_op_q;
  slot_t     s1_slot_q;
  vreg_idx_t s1_vd_q;
  vreg_idx_t s1_vs1_q;
  vreg_idx_t s1_vs2_q;
  elem_t     s1_scalar_q;

  // Execute stage
  logic      s2_valid_q;
  logic      s2_en_q;
  logic      s2_last_q;
  vec_op_e   s2_op_q;
  slot_t     s2_slot_q;
  vreg_idx_t s2_vd_q;
  elem_t     s2_a_q;
  elem_t     s2_b_q;
  elem_t     s2_scalar_q;

  elem_t     result;
  logic      s2_red;
  logic      s2_wr;

  //////////////////////////////////////////////////////////////////////
  // Pipeline registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= beat_valid_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_op_q     <= beat_op_i;
    s1_slot_q   <= beat_slot_i;
    s1_vd_q     <= beat_vd_i;
    s1_vs1_q    <= beat_vs1_i;
    s1_vs2_q    <= beat_vs2_i;
    s1_scalar_q <= beat_scalar_i;
    s1_en_q     <= beat_en_i;
    s1_last_q   <= beat_last_i;
    // Operand read from the register file
    s2_a_q      <= rf_q[s1_vs1_q][s1_slot_q];
    s2_b_q      <= rf_q[s1_vs2_q][s1_slot_q];
    s2_op_q     <= s1_op_q;
    s2_slot_q   <= s1_slot_q;
    s2_vd_q     <= s1_vd_q;
    s2_scalar_q <= s1_scalar_q;
    s2_en_q     <= s1_en_q;
    s2_last_q   <= s1_last_q;
  end

  //////////////////////////////////////////////////////////////////////
  // Execute and write back
  //////////////////////////////////////////////////////////////////////

  // vs2 is the first source, as in RVV (vsub gives vs2 - vs1)
  always_comb begin
    case (s2_op_q)
      OP_VADD_VV: result = s2_b_q + s2_a_q;
      OP_VSUB_VV: result = s2_b_q - s2_a_q;
      OP_VAND_VV: result = s2_b_q & s2_a_q;
      OP_VXOR_VV: result = s2_b_q ^ s2_a_q;
      OP_VADD_VX: result = s2_b_q + s2_scalar_q;
      OP_VMV_VX:  result = s2_scalar_q;
      default:    result = s2_b_q;
    endcase
  end

  assign s2_red = s2_valid_q && ((s2_op_q == OP_VREDSUM) || (s2_op_q == OP_VMV_XS));
  assign s2_wr  = s2_valid_q && s2_en_q && !s2_red;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < NR_VREGS; r++) begin
        for (int s = 0; s < ELEMS_PER_LANE; s++) begin
          rf_q[r][s] <= '0;
        end
      end
    end else if (s2_wr) begin
      rf_q[s2_vd_q][s2_slot_q] <= result;
    end
  end

  // Disabled lanes contribute zero to the sum
  assign red_elem_o  = (s2_red && s2_en_q) ? s2_b_q : '0;
  assign red_valid_o = s2_red;
  assign red_last_o  = s2_red && s2_last_q;

endmodule

`default_nettype wire

//--- verilog/vec_reduce.sv
`timescale 1ns/1ps
`default_nettype none

module vec_reduce import vec_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Lanes
  input  elem_t [NR_LANES-1:0] red_elem_i,
  input  logic                 red_valid_i,
  input  logic                 red_last_i,
  // Dispatcher
  output elem_t                red_sum_o,
  output logic                 red_done_o
);

  elem_t lane_sum;
  elem_t acc_q;
  logic  fresh_q;
  logic  done_q;

  //////////////////////////////////////////////////////////////////////
  // Cross-lane adder tree
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    lane_sum = '0;
    for (int l = 0; l < NR_LANES; l++) begin
      lane_sum = lane_sum + red_elem_i[l];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Accumulator
  //////////////////////////////////////////////////////////////////////

  // fresh_q marks the first beat of a new reduction
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q   <= '0;
      fresh_q <= 1'b1;
      done_q  <= 1'b0;
    end else begin
      done_q <= red_valid_i && red_last_i;
      if (red_valid_i) begin
        acc_q   <= (fresh_q ? elem_t'(0) : acc_q) + lane_sum;
        fresh_q <= red_last_i;
      end
    end
  end

  // Total stays put until the next reduction starts
  assign red_sum_o  = acc_q;
  assign red_done_o = done_q;

endmodule

`default_nettype wire

//--- verilog/vec_top.sv
`timescale 1ns/1ps
`default_nettype none

module vec_top import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Scalar core request
  input  vec_op_e   acc_op_i,
  input  vreg_idx_t acc_vd_i,
  input  vreg_idx_t acc_vs1_i,
  input  vreg_idx_t acc_vs2_i,
  input  elem_t     acc_scalar_i,
  input  logic      acc_req_valid_i,
  output logic      acc_req_ready_o,
  // Scalar core response
  output elem_t     acc_resp_data_o,
  output logic      acc_resp_valid_o,
  input  logic      acc_resp_ready_i
);

  // Dispatcher to sequencer
  vec_op_e    seq_op;
  vreg_idx_t  seq_vd;
  vreg_idx_t  seq_vs1;
  vreg_idx_t  seq_vs2;
  elem_t      seq_scalar;
  vl_t        seq_vl;
  logic       seq_valid;
  logic       seq_ready;
  // Beat broadcast
  logic       beat_valid;
  vec_op_e    beat_op;
  slot_t      beat_slot;
  vreg_idx_t  beat_vd;
  vreg_idx_t  beat_vs1;
  vreg_idx_t  beat_vs2;
  elem_t      beat_scalar;
  lane_mask_t beat_en;
  logic       beat_last;
  // Lanes to reduction unit, valid and last come from lane 0
  elem_t [NR_LANES-1:0] red_elem;
  lane_mask_t           lane_red_valid;
  lane_mask_t           lane_red_last;
  elem_t                red_sum;
  logic                 red_done;

  vec_dispatcher i_dispatcher (
    .clk_i           (clk_i           ),
    .rst_n_i         (rst_n_i         ),
    .acc_op_i        (acc_op_i        ),
    .acc_vd_i        (acc_vd_i        ),
    .acc_vs1_i       (acc_vs1_i       ),
    .acc_vs2_i       (acc_vs2_i       ),
    .acc_scalar_i    (acc_scalar_i    ),
    .acc_req_valid_i (acc_req_valid_i ),
    .acc_req_ready_o (acc_req_ready_o ),
    .acc_resp_data_o (acc_resp_data_o ),
    .acc_resp_valid_o(acc_resp_valid_o),
    .acc_resp_ready_i(acc_resp_ready_i),
    .seq_op_o        (seq_op          ),
    .seq_vd_o        (seq_vd          ),
    .seq_vs1_o       (seq_vs1         ),
    .seq_vs2_o       (seq_vs2         ),
    .seq_scalar_o    (seq_scalar      ),
    .seq_vl_o        (seq_vl          ),
    .seq_valid_o     (seq_valid       ),
    .seq_ready_i     (seq_ready       ),
    .red_sum_i       (red_sum         ),
    .red_done_i      (red_done        )
  );

  vec_sequencer i_sequencer (
    .clk_i        (clk_i      ),
    .rst_n_i      (rst_n_i    ),
    .seq_op_i     (seq_op     ),
    .seq_vd_i     (seq_vd     ),
    .seq_vs1_i    (seq_vs1    ),
    .seq_vs2_i    (seq_vs2    ),
    .seq_scalar_i (seq_scalar ),
    .seq_vl_i     (seq_vl     ),
    .seq_valid_i  (seq_valid  ),
    .seq_ready_o  (seq_ready  ),
    .beat_valid_o (beat_valid ),
    .beat_op_o    (beat_op    ),
    .beat_slot_o  (beat_slot  ),
    .beat_vd_o    (beat_vd    ),
    .beat_vs1_o   (beat_vs1   ),
    .beat_vs2_o   (beat_vs2   ),
    .beat_scalar_o(beat_scalar),
    .beat_en_o    (beat_en    ),
    .beat_last_o  (beat_last  )
  );

  for (genvar lane = 0; lane < NR_LANES; lane++) begin : gen_lanes
    vec_lane i_lane (
      .clk_i        (clk_i               ),
      .rst_n_i      (rst_n_i             ),
      .beat_valid_i (beat_valid          ),
      .beat_op_i    (beat_op             ),
      .beat_slot_i  (beat_slot           ),
      .beat_vd_i    (beat_vd             ),
      .beat_vs1_i   (beat_vs1            ),
      .beat_vs2_i   (beat_vs2            ),
      .beat_scalar_i(beat_scalar         ),
      .beat_en_i    (beat_en[lane]       ),
      .beat_last_i  (beat_last           ),
      .red_elem_o   (red_elem[lane]      ),
      .red_valid_o  (lane_red_valid[lane]),
      .red_last_o   (lane_red_last[lane] )
    );
  end : gen_lanes

  vec_reduce i_reduce (
    .clk_i      (clk_i            ),
    .rst_n_i    (rst_n_i          ),
    .red_elem_i (red_elem         ),
    .red_valid_i(lane_red_valid[0]),
    .red_last_i (lane_red_last[0] ),
    .red_sum_o  (red_sum          ),
    .red_done_o (red_done         )
  );

endmodule

`default_nettype wire

//--- bench/vec_model.svh
`ifndef VEC_MODEL_SVH
`define VEC_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Reference model of the register file and vector length
//////////////////////////////////////////////////////////////////////

// Element i of register r, index in architectural order
elem_t       model_rf [NR_VREGS][MAX_VL];
int unsigned model_vl;
elem_t       rng_state;

function automatic void model_reset();
  for (int r = 0; r < NR_VREGS; r++) begin
    for (int i = 0; i < MAX_VL; i++) begin
      model_rf[r][i] = '0;
    end
  end
  model_vl  = MAX_VL;
  rng_state = 32'd80;
endfunction

// Xorshift32, shifts 13, 17, 5
function automatic elem_t next_rand();
  elem_t x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

// RVV operand order, vs2 is the first source
function automatic elem_t element_result(input vec_op_e op, input elem_t src2,
                                         input elem_t src1, input elem_t scalar);
  case (op)
    OP_VADD_VV: return src2 + src1;
    OP_VSUB_VV: return src2 - src1;
    OP_VAND_VV: return src2 & src1;
    OP_VXOR_VV: return src2 ^ src1;
    OP_VADD_VX: return src2 + scalar;
    OP_VMV_VX:  return scalar;
    default:    return src2;
  endcase
endfunction

// Applies one instruction and returns the scalar response, if any
function automatic elem_t model_exec(input vec_op_e op, input vreg_idx_t vd,
                                     input vreg_idx_t vs1, input vreg_idx_t vs2,
                                     input elem_t scalar);
  elem_t sum;
  sum = '0;
  case (op)
    OP_SETVL: begin
      model_vl = (scalar > MAX_VL) ? MAX_VL : scalar;
      sum      = model_vl;
    end
    OP_VREDSUM: begin
      for (int i = 0; i < model_vl; i++) begin
        sum = sum + model_rf[vs2][i];
      end
    end
    OP_VMV_XS: sum = model_rf[vs2][scalar % MAX_VL];
    default: begin
      // Tail elements at vl and above keep their value
      for (int i = 0; i < model_vl; i++) begin
        model_rf[vd][i] = element_result(op, model_rf[vs2][i], model_rf[vs1][i], scalar);
      end
    end
  endcase
  return sum;
endfunction

`endif

//--- bench/vec_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vec_top_tb import vec_pkg::*; ();

  // Roughly 200 instructions of under 12 cycles each, about 2.5x margin
  localparam int unsigned TIMEOUT_CYCLES = 6000;

  logic      clk_i;
  logic      rst_n_i;
  vec_op_e   acc_op_i;
  vreg_idx_t acc_vd_i;
  vreg_idx_t acc_vs1_i;
  vreg_idx_t acc_vs2_i;
  elem_t     acc_scalar_i;
  logic      acc_req_valid_i;
  logic      acc_req_ready_o;
  elem_t     acc_resp_data_o;
  logic      acc_resp_valid_o;
  logic      acc_resp_ready_i;

  int unsigned check_count;
  int unsigned error_count;
  int unsigned cycles;

  `include "vec_model.svh"

  vec_top dut0 (
    .clk_i           (clk_i           ),
    .rst_n_i         (rst_n_i         ),
    .acc_op_i        (acc_op_i        ),
    .acc_vd_i        (acc_vd_i        ),
    .acc_vs1_i       (acc_vs1_i       ),
    .acc_vs2_i       (acc_vs2_i       ),
    .acc_scalar_i    (acc_scalar_i    ),
    .acc_req_valid_i (acc_req_valid_i ),
    .acc_req_ready_o (acc_req_ready_o ),
    .acc_resp_data_o (acc_resp_data_o ),
    .acc_resp_valid_o(acc_resp_valid_o),
    .acc_resp_ready_i(acc_resp_ready_i)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // Driver and check tasks, all entered and left on a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic compare(input string name, input elem_t expected, input elem_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED: %s expected %08h actual %08h at %0t",
               name, expected, actual, $time);
    end
  endtask

  // Outputs sampled 10 ns after the falling edge
  task automatic send_instr(input vec_op_e op, input vreg_idx_t vd, input vreg_idx_t vs1,
                            input vreg_idx_t vs2, input elem_t scalar);
    acc_op_i        = op;
    acc_vd_i        = vd;
    acc_vs1_i       = vs1;
    acc_vs2_i       = vs2;
    acc_scalar_i    = scalar;
    acc_req_valid_i = 1'b1;
    #10;
    while (!acc_req_ready_o) begin
      @(negedge clk_i);
      #10;
    end
    @(negedge clk_i);
    acc_req_valid_i = 1'b0;
  endtask

  task automatic wait_resp();
    #10;
    while (!acc_resp_valid_o) begin
      @(negedge clk_i);
      #10;
    end
  endtask

  task automatic get_resp(input elem_t expected);
    wait_resp();
    compare("acc_resp_data_o", expected, acc_resp_data_o);
    @(negedge clk_i);
  endtask

  task automatic run_instr(input vec_op_e op, input vreg_idx_t vd, input vreg_idx_t vs1,
                           input vreg_idx_t vs2, input elem_t scalar);
    elem_t expected;
    expected = model_exec(op, vd, vs1, vs2, scalar);
    send_instr(op, vd, vs1, vs2, scalar);
    if ((op == OP_SETVL) || (op == OP_VREDSUM) || (op == OP_VMV_XS)) begin
      get_resp(expected);
    end
  endtask

  // Element reads with random upper index bits
  task automatic check_vreg(input vreg_idx_t vreg);
    elem_t idx;
    for (int i = 0; i < MAX_VL; i++) begin
      idx = (next_rand() & 32'hFFFF_FFF0) | elem_t'(i);
      run_instr(OP_VMV_XS, 0, 0, vreg, idx);
    end
  endtask

  // Broadcasts at shrinking lengths give uneven contents
  task automatic fill_layers(input vreg_idx_t vreg);
    elem_t len;
    run_instr(OP_SETVL, 0, 0, 0, MAX_VL);
    run_instr(OP_VMV_VX, vreg, 0, 0, next_rand());
    for (int k = 0; k < 3; k++) begin
      len = 1 + (next_rand() % MAX_VL);
      run_instr(OP_SETVL, 0, 0, 0, len);
      run_instr(OP_VMV_VX, vreg, 0, 0, next_rand());
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  // Vector length out of reset covers the last element
  task automatic test_reset_vl();
    run_instr(OP_VMV_VX, 1, 0, 0, next_rand());
    run_instr(OP_VMV_XS, 0, 0, 1, MAX_VL - 1);
  endtask

  task automatic test_setvl();
    elem_t unused;
    unused = model_exec(OP_SETVL, 0, 0, 0, 0);
    send_instr(OP_SETVL, 0, 0, 0, 0);
    get_resp(32'd0);
    unused = model_exec(OP_SETVL, 0, 0, 0, 5);
    send_instr(OP_SETVL, 0, 0, 0, 5);
    get_resp(32'd5);
    unused = model_exec(OP_SETVL, 0, 0, 0, 16);
    send_instr(OP_SETVL, 0, 0, 0, 16);
    get_resp(32'd16);
    unused = model_exec(OP_SETVL, 0, 0, 0, 40);
    send_instr(OP_SETVL, 0, 0, 0, 40);
    get_resp(32'd16);
  endtask

  task automatic test_elem_ops();
    fill_layers(1);
    fill_layers(2);
    run_instr(OP_SETVL, 0, 0, 0, 16);
    run_instr(OP_VADD_VV, 3, 1, 2, 0);
    run_instr(OP_VSUB_VV, 4, 1, 2, 0);
    run_instr(OP_VAND_VV, 5, 1, 2, 0);
    run_instr(OP_VXOR_VV, 6, 1, 2, 0);
    run_instr(OP_VADD_VX, 7, 0, 2, next_rand());
    for (int v = 1; v < NR_VREGS; v++) begin
      check_vreg(vreg_idx_t'(v));
    end
  endtask

  task automatic test_tail();
    run_instr(OP_SETVL, 0, 0, 0, 16);
    run_instr(OP_VMV_VX, 3, 0, 0, next_rand());
    run_instr(OP_SETVL, 0, 0, 0, 6);
    run_instr(OP_VADD_VV, 3, 1, 2, 0);
    check_vreg(3);
  endtask

  task automatic test_redsum();
    run_instr(OP_SETVL, 0, 0, 0, 16);
    run_instr(OP_VREDSUM, 0, 0, 4, 0);
    run_instr(OP_SETVL, 0, 0, 0, 7);
    run_instr(OP_VREDSUM, 0, 0, 4, 0);
    run_instr(OP_SETVL, 0, 0, 0, 1);
    run_instr(OP_VREDSUM, 0, 0, 4, 0);
    run_instr(OP_SETVL, 0, 0, 0, 0);
    run_instr(OP_VREDSUM, 0, 0, 4, 0);
  endtask

  // Single-beat instructions, each reading the destination of the one before
  task automatic test_chain();
    run_instr(OP_SETVL, 0, 0, 0, 3);
    run_instr(OP_VADD_VX, 1, 0, 1, next_rand());
    run_instr(OP_VADD_VV, 4, 1, 2, 0);
    run_instr(OP_VSUB_VV, 5, 4, 1, 0);
    run_instr(OP_VXOR_VV, 6, 5, 4, 0);
    run_instr(OP_VAND_VV, 0, 6, 5, 0);
    run_instr(OP_VREDSUM, 0, 0, 0, 0);
    check_vreg(0);
  endtask

  task automatic test_backpressure();
    elem_t expected;
    elem_t held;
    run_instr(OP_SETVL, 0, 0, 0, 11);
    expected = model_exec(OP_VREDSUM, 0, 0, 3, 0);
    acc_resp_ready_i = 1'b0;
    send_instr(OP_VREDSUM, 0, 0, 3, 0);
    wait_resp();
    held = acc_resp_data_o;
    repeat (20) begin
      @(negedge clk_i);
      #10;
      compare("acc_resp_valid_o", 32'd1, elem_t'(acc_resp_valid_o));
      compare("acc_resp_data_o", held, acc_resp_data_o);
      compare("acc_req_ready_o", 32'd0, elem_t'(acc_req_ready_o));
    end
    @(negedge clk_i);
    acc_resp_ready_i = 1'b1;
    get_resp(expected);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and timeout
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk_i            = 1'b0;
    rst_n_i          = 1'b0;
    acc_op_i         = OP_SETVL;
    acc_vd_i         = '0;
    acc_vs1_i        = '0;
    acc_vs2_i        = '0;
    acc_scalar_i     = '0;
    acc_req_valid_i  = 1'b0;
    acc_resp_ready_i = 1'b1;
    check_count      = 0;
    error_count      = 0;
    cycles           = 0;
    model_reset();
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    #10;
    compare("acc_resp_valid_o", 32'd0, elem_t'(acc_resp_valid_o));
    compare("acc_req_ready_o", 32'd1, elem_t'(acc_req_ready_o));
    @(negedge clk_i);
    test_reset_vl();
    test_setvl();
    test_elem_ops();
    test_tail();
    test_redsum();
    test_chain();
    test_backpressure();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    wait (cycles >= TIMEOUT_CYCLES);
    $display("Run hung, no end of test within %0d cycles", TIMEOUT_CYCLES);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- vec_top.f
+incdir+bench
verilog/vec_pkg.sv
verilog/vec_dispatcher.sv
verilog/vec_sequencer.sv
verilog/vec_lane.sv
verilog/vec_reduce.sv
verilog/vec_top.sv
bench/vec_top_tb.sv
